/* mem_stage.f */
mem_stage_pkg.sv
load_align.sv
store_align.sv
mem_result_merge.sv
mem_stage.sv
mem_stage_checker.sv
mem_stage_tb.sv

/* Bender.yml */
package:
  name: mem_stage

sources:
  - mem_stage_pkg.sv
  - load_align.sv
  - store_align.sv
  - mem_result_merge.sv
  - mem_stage.sv
  - target: simulation
    files:
      - mem_stage_checker.sv
      - mem_stage_tb.sv

/* mem_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage_tb;

    localparam int clk_period   = 100;
    localparam int reset_cycles = 10;
    // sc after reset, 7 loads and 5 stores at 4 offsets, ll/sc/sc/lw, 4 alu ops, 2 idle
    localparam int num_ops      = 1 + 7 * 4 + 5 * 4 + 4 + 4 + 2;
    localparam int timeout_ns   = (reset_cycles + num_ops + 20) * clk_period;

    logic                          clk;
    logic                          reset_i;
    mem_stage_pkg::aluop_t         aluop_i;
    mem_stage_pkg::word_t          mem_addr_i;
    mem_stage_pkg::word_t          reg2_data_i;
    mem_stage_pkg::word_t          alu_res_i;
    mem_stage_pkg::reg_addr_t      waddr_i;
    logic                          reg_we_i;
    wire mem_stage_pkg::word_t     mem_data_i;
    wire mem_stage_pkg::word_t     mem_addr_o;
    wire mem_stage_pkg::word_t     mem_data_o;
    wire mem_stage_pkg::sel_t      mem_sel_o;
    wire                           mem_ce_o;
    wire                           mem_we_o;
    wire mem_stage_pkg::reg_addr_t waddr_o;
    wire                           reg_we_o;
    wire mem_stage_pkg::word_t     wdata_o;

    mem_stage_pkg::word_t     ram [16];      // ram model, written by the dut
    mem_stage_pkg::word_t     exp_ram [16];  // expected contents
    logic                     link_q;        // model link bit
    logic                     wb_valid = 1'b0;
    logic                     exp_we_q;      // expected mem/wb register
    mem_stage_pkg::word_t     exp_wdata_q;
    mem_stage_pkg::reg_addr_t exp_waddr_q;
    string                    test_name;
    string                    name_q;        // name of the op now at writeback

    mem_stage mem_stage_i (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // big-endian, combinational read, lane writes at the edge
    assign mem_data_i = ram[mem_addr_o[5:2]];
    always @(posedge clk) begin
        if (mem_ce_o && mem_we_o) begin
            for (int k = 0; k < 4; k++) begin
                if (mem_sel_o[3-k]) begin  // sel bit 3 is byte 0
                    ram[mem_addr_o[5:2]][31-8*k -: 8] <= mem_data_o[31-8*k -: 8];
                end
            end
        end
    end

    // byte a of a word, a = 0 is the lowest address and the msb
    function automatic logic [7:0] byte_at(mem_stage_pkg::word_t w, int a);
        return w[31-8*a -: 8];
    endfunction

    function automatic mem_stage_pkg::word_t put_byte(mem_stage_pkg::word_t w, int a,
                                                      logic [7:0] b);
        w[31-8*a -: 8] = b;
        return w;
    endfunction

    function automatic mem_stage_pkg::word_t lane_mask(mem_stage_pkg::sel_t s);
        mem_stage_pkg::word_t m;
        for (int k = 0; k < 4; k++) begin
            m = put_byte(m, k, {8{s[3-k]}});
        end
        return m;
    endfunction

    function automatic void ref_mem_stage(
        input  mem_stage_pkg::aluop_t op,
        input  mem_stage_pkg::word_t  addr, reg2, alu, mword,
        input  logic                  link, rst,
        output logic                  ce, we,
        output mem_stage_pkg::sel_t   sel,
        output mem_stage_pkg::word_t  wr, maddr, wb
    );
        int          n;
        logic [15:0] half;
        n     = addr[1:0];
        ce    = 1'b0;
        we    = 1'b0;
        sel   = '0;
        wr    = '0;
        maddr = addr;
        wb    = alu;                                          // stores and alu ops
        half  = {byte_at(mword, n), byte_at(mword, n | 1)};  // only used at even offsets
        case (op)
            mem_stage_pkg::alu_lb_op, mem_stage_pkg::alu_lbu_op: begin
                ce       = 1'b1;
                sel[3-n] = 1'b1;
                wb       = {24'b0, byte_at(mword, n)};
                if (op == mem_stage_pkg::alu_lb_op && wb[7]) wb[31:8] = '1;
            end
            mem_stage_pkg::alu_lh_op, mem_stage_pkg::alu_lhu_op: begin
                ce = 1'b1;
                wb = '0;  // misaligned gives zero, no lanes
                if (n % 2 == 0) begin
                    sel[3-n] = 1'b1;
                    sel[2-n] = 1'b1;
                    wb       = {16'b0, half};
                    if (op == mem_stage_pkg::alu_lh_op && half[15]) wb[31:16] = '1;
                end
            end
            mem_stage_pkg::alu_lw_op, mem_stage_pkg::alu_ll_op: begin
                ce = 1'b1;
                wb = '0;
                if (n == 0 || op == mem_stage_pkg::alu_ll_op) begin
                    sel = 4'b1111;
                    wb  = mword;
                end
            end
            mem_stage_pkg::alu_lwl_op, mem_stage_pkg::alu_lwr_op: begin
                ce    = 1'b1;
                sel   = 4'b1111;
                maddr = {addr[31:2], 2'b00};
                wb    = reg2;  // untouched bytes keep the old rt
                for (int k = 0; k < 4; k++) begin
                    if (op == mem_stage_pkg::alu_lwl_op && k >= n) begin
                        wb = put_byte(wb, k - n, byte_at(mword, k));
                    end
                    if (op == mem_stage_pkg::alu_lwr_op && k <= n) begin
                        wb = put_byte(wb, 3 - n + k, byte_at(mword, k));
                    end
                end
            end
            mem_stage_pkg::alu_sb_op: begin
                ce       = 1'b1;
                we       = 1'b1;
                sel[3-n] = 1'b1;
                wr       = {4{reg2[7:0]}};  // byte copied to every lane
            end
            mem_stage_pkg::alu_sh_op: begin
                ce = 1'b1;
                we = 1'b1;  // write even when misaligned, just no lanes
                wr = {2{reg2[15:0]}};
                if (n % 2 == 0) begin
                    sel[3-n] = 1'b1;
                    sel[2-n] = 1'b1;
                end
            end
            mem_stage_pkg::alu_sw_op: begin
                ce = 1'b1;
                we = 1'b1;
                wr = reg2;
                if (n == 0) sel = 4'b1111;
            end
            mem_stage_pkg::alu_swl_op, mem_stage_pkg::alu_swr_op: begin
                ce    = 1'b1;
                we    = 1'b1;
                maddr = {addr[31:2], 2'b00};
                for (int k = 0; k < 4; k++) begin
                    if (op == mem_stage_pkg::alu_swl_op && k >= n) begin
                        sel[3-k] = 1'b1;
                        wr       = put_byte(wr, k, byte_at(reg2, k - n));
                    end
                    if (op == mem_stage_pkg::alu_swr_op && k <= n) begin
                        sel[3-k] = 1'b1;
                        wr       = put_byte(wr, k, byte_at(reg2, 3 - n + k));
                    end
                end
            end
            mem_stage_pkg::alu_sc_op: begin
                wb = '0;  // failed sc, ram idle
                if (link) begin
                    ce  = 1'b1;
                    we  = 1'b1;
                    sel = 4'b1111;
                    wr  = reg2;
                    wb  = 32'd1;
                end
            end
            default: ;
        endcase
        if (rst) begin
            ce  = 1'b0;
            we  = 1'b0;
            sel = '0;
        end
    endfunction

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(string name, string what, mem_stage_pkg::word_t exp,
                              mem_stage_pkg::word_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: %s expected %h actual %h", name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_sel(string name, string what, mem_stage_pkg::sel_t exp,
                             mem_stage_pkg::sel_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: %s expected %b actual %b", name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_addr(string name, string what, mem_stage_pkg::reg_addr_t exp,
                              mem_stage_pkg::reg_addr_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: %s expected %0d actual %0d", name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(string name, string what, logic exp, logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: %s expected %b actual %b", name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic drive_op(string name, mem_stage_pkg::aluop_t op, mem_stage_pkg::word_t addr,
                            mem_stage_pkg::word_t reg2, mem_stage_pkg::word_t alu, logic we);
        @(posedge clk);
        test_name    = name;
        aluop_i     <= op;
        mem_addr_i  <= addr;
        reg2_data_i <= reg2;
        alu_res_i   <= alu;
        waddr_i     <= mem_stage_pkg::reg_addr_t'($urandom);
        reg_we_i    <= we;
    endtask

    // ram request checked mid cycle, writeback one cycle later
    always @(negedge clk) begin : compare
        logic                 ce, we;
        mem_stage_pkg::sel_t  sel;
        mem_stage_pkg::word_t wr, maddr, wb, mask;
        if (wb_valid) begin
            check_bit(name_q, "reg_we_o", exp_we_q, reg_we_o);
            check_word(name_q, "wdata_o", exp_wdata_q, wdata_o);
            if (exp_we_q) check_addr(name_q, "waddr_o", exp_waddr_q, waddr_o);
        end
        ref_mem_stage(aluop_i, mem_addr_i, reg2_data_i, alu_res_i, exp_ram[mem_addr_i[5:2]],
                      link_q, reset_i, ce, we, sel, wr, maddr, wb);
        check_bit(test_name, "mem_ce_o", ce, mem_ce_o);
        check_bit(test_name, "mem_we_o", we, mem_we_o);
        check_sel(test_name, "mem_sel_o", sel, mem_sel_o);
        if (ce) check_word(test_name, "mem_addr_o", maddr, mem_addr_o);
        mask = lane_mask(sel);
        if (we) begin
            check_word(test_name, "mem_data_o", wr, mem_data_o);
            exp_ram[maddr[5:2]] = (exp_ram[maddr[5:2]] & ~mask) | (wr & mask);
        end
        // link bit as it stands after the coming edge
        if (reset_i) link_q = 1'b0;
        else if (aluop_i == mem_stage_pkg::alu_ll_op) link_q = 1'b1;
        else if (aluop_i == mem_stage_pkg::alu_sc_op) link_q = 1'b0;
        exp_we_q    = reset_i ? 1'b0 : reg_we_i;
        exp_wdata_q = reset_i ? '0 : wb;
        exp_waddr_q = waddr_i;
        name_q      = test_name;
        wb_valid    = 1'b1;
    end

    initial begin
        mem_stage_pkg::aluop_t ld_ops [7];
        mem_stage_pkg::aluop_t st_ops [5];
        mem_stage_pkg::word_t  addr;
        ld_ops = '{mem_stage_pkg::alu_lb_op, mem_stage_pkg::alu_lbu_op, mem_stage_pkg::alu_lh_op,
                   mem_stage_pkg::alu_lhu_op, mem_stage_pkg::alu_lw_op, mem_stage_pkg::alu_lwl_op,
                   mem_stage_pkg::alu_lwr_op};
        st_ops = '{mem_stage_pkg::alu_sb_op, mem_stage_pkg::alu_sh_op, mem_stage_pkg::alu_sw_op,
                   mem_stage_pkg::alu_swl_op, mem_stage_pkg::alu_swr_op};
        void'($urandom(32'hf8fa2693));
        reset_i     = 1'b1;
        aluop_i     = mem_stage_pkg::alu_lw_op;  // a load held during reset
        mem_addr_i  = '0;
        reg2_data_i = '0;
        alu_res_i   = '0;
        waddr_i     = '0;
        reg_we_i    = 1'b1;
        test_name   = "reset";
        for (int i = 0; i < 16; i++) begin
            ram[i]     = 32'h9e37_79b9 * (i + 1);  // address dependent fill
            exp_ram[i] = ram[i];
        end
        repeat (reset_cycles - 1) @(posedge clk);
        drive_op("sc after reset", mem_stage_pkg::alu_sc_op, 32'h10, $urandom, $urandom, 1'b1);
        reset_i <= 1'b0;  // released on the same edge
        for (int off = 0; off < 4; off++) begin
            foreach (ld_ops[i]) begin
                addr = ($urandom & 32'h3c) | off;
                drive_op($sformatf("load %02h offset %0d", ld_ops[i], off), ld_ops[i], addr,
                         $urandom, $urandom, 1'b1);
            end
            foreach (st_ops[i]) begin
                addr = ($urandom & 32'h3c) | off;
                drive_op($sformatf("store %02h offset %0d", st_ops[i], off), st_ops[i], addr,
                         $urandom, $urandom, 1'b0);
            end
        end
        addr = $urandom & 32'h3c;
        drive_op("ll", mem_stage_pkg::alu_ll_op, addr, $urandom, $urandom, 1'b1);
        drive_op("sc after ll", mem_stage_pkg::alu_sc_op, addr, $urandom, $urandom, 1'b1);
        drive_op("second sc", mem_stage_pkg::alu_sc_op, addr, $urandom, $urandom, 1'b1);
        drive_op("lw after sc", mem_stage_pkg::alu_lw_op, addr, $urandom, $urandom, 1'b1);
        repeat (4) begin
            drive_op("alu pass", mem_stage_pkg::aluop_t'($urandom & 32'h3f), $urandom, $urandom,
                     $urandom, $urandom % 2 == 1);
        end
        drive_op("idle", mem_stage_pkg::alu_nop_op, '0, '0, '0, 1'b0);
        drive_op("idle", mem_stage_pkg::alu_nop_op, '0, '0, '0, 1'b0);
        repeat (2) @(posedge clk);  // last writeback compared, no write pending
        foreach (ram[i]) begin
            check_word("ram contents", $sformatf("word %0d", i), exp_ram[i], ram[i]);
        end
        $display("TEST OK");
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("simulation timed out after %0d ns, stimulus did not finish", timeout_ns);
        abort_run();
    end

endmodule

`default_nettype wire

/* mem_stage_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage_checker (
    input wire                      clk,
    input wire                      reset_i,
    input wire                      mem_ce_i,
    input wire                      mem_we_i,
    input wire mem_stage_pkg::sel_t mem_sel_i,
    input wire                      wb_we_i     // registered reg_we_o
);

    // a write is always a ram access
    we_needs_ce: assert property (@(posedge clk) mem_we_i |-> mem_ce_i)
        else $error("mem_we_o high without mem_ce_o");

    reset_idle: assert property (@(posedge clk)
        reset_i |-> !mem_ce_i && !mem_we_i && mem_sel_i == '0)
        else $error("ram request active during reset");

    // lanes only with an access
    sel_needs_ce: assert property (@(posedge clk) (mem_sel_i != '0) |-> mem_ce_i)
        else $error("mem_sel_o nonzero without mem_ce_o");

    wb_off_after_reset: assert property (@(posedge clk) reset_i |=> !wb_we_i)
        else $error("reg_we_o high in the cycle after reset");

endmodule

bind mem_result_merge mem_stage_checker mem_stage_checker_i (
    .clk       (clk),
    .reset_i   (reset_i),
    .mem_ce_i  (mem_ce_o),
    .mem_we_i  (mem_we_o),
    .mem_sel_i (mem_sel_o),
    .wb_we_i   (reg_we_o)
);

`default_nettype wire

/* mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  wire                           clk,
    input  wire                           reset_i,
    input  wire mem_stage_pkg::aluop_t    aluop_i,
    input  wire mem_stage_pkg::word_t     mem_addr_i,
    input  wire mem_stage_pkg::word_t     reg2_data_i,
    input  wire mem_stage_pkg::word_t     mem_data_i,
    input  wire mem_stage_pkg::word_t     alu_res_i,
    input  wire mem_stage_pkg::reg_addr_t waddr_i,
    input  wire                           reg_we_i,
    output wire mem_stage_pkg::word_t     mem_addr_o,
    output wire                           mem_ce_o,
    output wire                           mem_we_o,
    output wire mem_stage_pkg::sel_t      mem_sel_o,
    output wire mem_stage_pkg::word_t     mem_data_o,
    output wire mem_stage_pkg::reg_addr_t waddr_o,
    output wire                           reg_we_o,
    output wire mem_stage_pkg::word_t     wdata_o
);

    wire                       ld_hit, ld_word_addr, ld_link;
    wire mem_stage_pkg::sel_t  ld_sel;
    wire mem_stage_pkg::word_t ld_data;
    wire                       st_hit, st_word_addr, st_cond;
    wire mem_stage_pkg::sel_t  st_sel;
    wire mem_stage_pkg::word_t st_data;

    load_align load_align_i (
        .aluop_i        (aluop_i),
        .addr_lo_i      (mem_addr_i[1:0]),  // byte offset only
        .mem_data_i     (mem_data_i),
        .reg2_data_i    (reg2_data_i),
        .ld_hit_o       (ld_hit),
        .ld_sel_o       (ld_sel),
        .ld_data_o      (ld_data),
        .ld_word_addr_o (ld_word_addr),
        .ld_link_o      (ld_link)
    );

    store_align store_align_i (
        .aluop_i        (aluop_i),
        .addr_lo_i      (mem_addr_i[1:0]),
        .reg2_data_i    (reg2_data_i),
        .st_hit_o       (st_hit),
        .st_sel_o       (st_sel),
        .st_data_o      (st_data),
        .st_word_addr_o (st_word_addr),
        .st_cond_o      (st_cond)
    );

    mem_result_merge mem_result_merge_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .ld_hit_i       (ld_hit),
        .ld_sel_i       (ld_sel),
        .ld_data_i      (ld_data),
        .ld_word_addr_i (ld_word_addr),
        .ld_link_i      (ld_link),
        .st_hit_i       (st_hit),
        .st_sel_i       (st_sel),
        .st_data_i      (st_data),
        .st_word_addr_i (st_word_addr),
        .st_cond_i      (st_cond),
        .mem_addr_i     (mem_addr_i),
        .alu_res_i      (alu_res_i),
        .waddr_i        (waddr_i),
        .reg_we_i       (reg_we_i),
        .mem_addr_o     (mem_addr_o),
        .mem_ce_o       (mem_ce_o),
        .mem_we_o       (mem_we_o),
        .mem_sel_o      (mem_sel_o),
        .mem_data_o     (mem_data_o),
        .waddr_o        (waddr_o),
        .reg_we_o       (reg_we_o),
        .wdata_o        (wdata_o)
    );

endmodule

`default_nettype wire

/* mem_result_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_result_merge (
    input  wire                          clk,
    input  wire                          reset_i,
    // load side
    input  wire                          ld_hit_i,
    input  wire mem_stage_pkg::sel_t     ld_sel_i,
    input  wire mem_stage_pkg::word_t    ld_data_i,
    input  wire                          ld_word_addr_i,
    input  wire                          ld_link_i,
    // store side
    input  wire                          st_hit_i,
    input  wire mem_stage_pkg::sel_t     st_sel_i,
    input  wire mem_stage_pkg::word_t    st_data_i,
    input  wire                          st_word_addr_i,
    input  wire                          st_cond_i,
    // from ex/mem
    input  wire mem_stage_pkg::word_t    mem_addr_i,
    input  wire mem_stage_pkg::word_t    alu_res_i,
    input  wire mem_stage_pkg::reg_addr_t waddr_i,
    input  wire                          reg_we_i,
    // ram request
    output mem_stage_pkg::word_t         mem_addr_o,
    output logic                         mem_ce_o,
    output logic                         mem_we_o,
    output mem_stage_pkg::sel_t          mem_sel_o,
    output mem_stage_pkg::word_t         mem_data_o,
    // mem/wb register
    output mem_stage_pkg::reg_addr_t     waddr_o,
    output logic                         reg_we_o,
    output mem_stage_pkg::word_t         wdata_o
);

    logic                 llbit_q;   // link bit
    logic                 sc_ok;     // sc with link still held
    logic                 st_go;     // store that really writes
    mem_stage_pkg::word_t wb_data;

    assign sc_ok = st_cond_i & llbit_q;
    assign st_go = st_hit_i & (~st_cond_i | llbit_q);  // failed sc leaves ram idle

    // ram held idle while in reset
    assign mem_ce_o   = ~reset_i & (ld_hit_i | st_go);
    assign mem_we_o   = ~reset_i & st_go;
    assign mem_sel_o  = reset_i  ? '0 :
                        ld_hit_i ? ld_sel_i :
                        st_go    ? st_sel_i : '0;
    assign mem_data_o = st_go ? st_data_i : '0;
    assign mem_addr_o = (ld_word_addr_i | st_word_addr_i) ? {mem_addr_i[31:2], 2'b00}
                                                          : mem_addr_i;

    // sc returns 1 on success, 0 otherwise
    assign wb_data = ld_hit_i  ? ld_data_i :
                     st_cond_i ? {{(mem_stage_pkg::reg_w-1){1'b0}}, sc_ok} :
                     alu_res_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            reg_we_o <= 1'b0;
            wdata_o  <= '0;
            llbit_q  <= 1'b0;
        end else begin
            reg_we_o <= reg_we_i;
            wdata_o  <= wb_data;
            if (ld_link_i) begin
                llbit_q <= 1'b1;  // ll sets
            end else if (sc_ok) begin
                llbit_q <= 1'b0;  // consumed by sc
            end
        end
    end

    // mem/wb destination
    always_ff @(posedge clk) begin
        waddr_o <= waddr_i;
    end

endmodule

`default_nettype wire

/* store_align.sv */
`timescale 1ns/1ps
`default_nettype none

module store_align (
    input  wire mem_stage_pkg::aluop_t aluop_i,
    input  wire [1:0]                  addr_lo_i,
    input  wire mem_stage_pkg::word_t  reg2_data_i,    // rt, the data to store
    output logic                       st_hit_o,
    output mem_stage_pkg::sel_t        st_sel_o,
    output mem_stage_pkg::word_t       st_data_o,
    output logic                       st_word_addr_o, // swl/swr use aligned addr
    output logic                       st_cond_o       // sc, gated by link bit downstream
);

    mem_stage_pkg::mem_word_u wr_word;  // write word under construction

    always_comb begin
        st_hit_o       = 1'b1;
        st_sel_o       = '0;
        wr_word.w      = reg2_data_i;
        st_word_addr_o = 1'b0;
        st_cond_o      = 1'b0;
        case (aluop_i)
            mem_stage_pkg::alu_sb_op: begin
                wr_word.b = {4{reg2_data_i[7:0]}};  // same byte on every lane
                st_sel_o  = 4'b1000 >> addr_lo_i;
            end
            mem_stage_pkg::alu_sh_op: begin
                wr_word.h = {2{reg2_data_i[15:0]}};
                if (!addr_lo_i[0]) begin
                    st_sel_o = addr_lo_i[1] ? 4'b0011 : 4'b1100;
                end
                // odd offset: write enabled, nothing selected
            end
            mem_stage_pkg::alu_sw_op: begin
                if (addr_lo_i == 2'b00) begin
                    st_sel_o = 4'b1111;
                end
            end
            mem_stage_pkg::alu_sc_op: begin
                st_sel_o  = 4'b1111;  // full word, no alignment check
                st_cond_o = 1'b1;
            end
            mem_stage_pkg::alu_swl_op: begin
                st_word_addr_o = 1'b1;
                // top 4-n bytes of rt, right justified
                st_sel_o  = 4'b1111 >> addr_lo_i;
                wr_word.w = reg2_data_i >> {addr_lo_i, 3'b000};
            end
            mem_stage_pkg::alu_swr_op: begin
                st_word_addr_o = 1'b1;
                // low n+1 bytes of rt, left justified
                st_sel_o  = 4'b1111 << (~addr_lo_i);
                wr_word.w = reg2_data_i << {~addr_lo_i, 3'b000};
            end
            default: begin
                st_hit_o  = 1'b0;
                wr_word.w = '0;
            end
        endcase
    end

    assign st_data_o = wr_word.w;

endmodule

`default_nettype wire

/* load_align.sv */
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  wire mem_stage_pkg::aluop_t aluop_i,
    input  wire [1:0]                  addr_lo_i,      // byte offset in word
    input  wire mem_stage_pkg::word_t  mem_data_i,     // ram read word, same cycle
    input  wire mem_stage_pkg::word_t  reg2_data_i,    // old rt value for lwl/lwr
    output logic                       ld_hit_o,
    output mem_stage_pkg::sel_t        ld_sel_o,
    output mem_stage_pkg::word_t       ld_data_o,
    output logic                       ld_word_addr_o, // force addr[1:0] to 0
    output logic                       ld_link_o       // ll, sets link bit
);

    mem_stage_pkg::mem_word_u rd_word;
    logic [7:0]               rd_byte;   // addressed byte
    logic [15:0]              rd_half;   // addressed halfword
    logic                     half_ok;

    assign rd_word = mem_data_i;
    assign rd_byte = rd_word.b[~addr_lo_i];     // offset 0 -> lane 3 (msb)
    assign rd_half = rd_word.h[~addr_lo_i[1]];  // offset 0 -> upper half
    assign half_ok = ~addr_lo_i[0];             // offsets 0 and 2 only

    always_comb begin
        ld_hit_o       = 1'b1;
        ld_sel_o       = '0;
        ld_data_o      = '0;  // misaligned loads return zero
        ld_word_addr_o = 1'b0;
        ld_link_o      = 1'b0;
        case (aluop_i)
            mem_stage_pkg::alu_lb_op: begin
                ld_sel_o  = 4'b1000 >> addr_lo_i;
                ld_data_o = {{24{rd_byte[7]}}, rd_byte};  // sign extend
            end
            mem_stage_pkg::alu_lbu_op: begin
                ld_sel_o  = 4'b1000 >> addr_lo_i;
                ld_data_o = {24'b0, rd_byte};
            end
            mem_stage_pkg::alu_lh_op: begin
                if (half_ok) begin
                    ld_sel_o  = addr_lo_i[1] ? 4'b0011 : 4'b1100;
                    ld_data_o = {{16{rd_half[15]}}, rd_half};
                end
            end
            mem_stage_pkg::alu_lhu_op: begin
                if (half_ok) begin
                    ld_sel_o  = addr_lo_i[1] ? 4'b0011 : 4'b1100;
                    ld_data_o = {16'b0, rd_half};
                end
            end
            mem_stage_pkg::alu_lw_op: begin
                if (addr_lo_i == 2'b00) begin
                    ld_sel_o  = 4'b1111;
                    ld_data_o = rd_word.w;
                end
            end
            mem_stage_pkg::alu_ll_op: begin
                ld_sel_o  = 4'b1111;  // no alignment check
                ld_data_o = rd_word.w;
                ld_link_o = 1'b1;
            end
            mem_stage_pkg::alu_lwl_op: begin
                ld_word_addr_o = 1'b1;
                ld_sel_o       = 4'b1111;
                // low 4-n bytes of word go to the top of rt
                case (addr_lo_i)
                    2'b00:   ld_data_o = rd_word.w;
                    2'b01:   ld_data_o = {rd_word.w[23:0], reg2_data_i[7:0]};
                    2'b10:   ld_data_o = {rd_word.w[15:0], reg2_data_i[15:0]};
                    default: ld_data_o = {rd_word.w[7:0], reg2_data_i[23:0]};
                endcase
            end
            mem_stage_pkg::alu_lwr_op: begin
                ld_word_addr_o = 1'b1;
                ld_sel_o       = 4'b1111;
                // high n+1 bytes of word go to the bottom of rt
                case (addr_lo_i)
                    2'b00:   ld_data_o = {reg2_data_i[31:8], rd_word.w[31:24]};
                    2'b01:   ld_data_o = {reg2_data_i[31:16], rd_word.w[31:16]};
                    2'b10:   ld_data_o = {reg2_data_i[31:24], rd_word.w[31:8]};
                    default: ld_data_o = rd_word.w;
                endcase
            end
            default: begin
                ld_hit_o = 1'b0;  // not a load
            end
        endcase
    end

endmodule

`default_nettype wire

/* mem_stage_pkg.sv */
`default_nettype none

package mem_stage_pkg;

    // data path widths
    localparam int reg_w      = 32;  // gpr and ram word
    localparam int reg_addr_w = 5;   // 32 gprs
    localparam int aluop_w    = 8;
    localparam int sel_w      = 4;   // one bit per byte lane, bit 3 = lowest address

    typedef logic [reg_w-1:0]      word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [aluop_w-1:0]    aluop_t;
    typedef logic [sel_w-1:0]      sel_t;

    // one ram word, big-endian
    // b[3] and h[1] sit at the lowest address and carry the msb
    typedef union packed {
        logic [sel_w-1:0][7:0]       b;  // byte view
        logic [sel_w/2-1:0][15:0]    h;  // halfword view
        word_t                       w;  // whole word
    } mem_word_u;

    // idle code, ram untouched
    localparam aluop_t alu_nop_op = 8'b0000_0000;

    // loads
    localparam aluop_t alu_lb_op  = 8'b1110_0000;
    localparam aluop_t alu_lbu_op = 8'b1110_0100;
    localparam aluop_t alu_lh_op  = 8'b1110_0001;
    localparam aluop_t alu_lhu_op = 8'b1110_0101;
    localparam aluop_t alu_lw_op  = 8'b1110_0011;
    localparam aluop_t alu_ll_op  = 8'b1111_0000;  // load linked
    localparam aluop_t alu_lwl_op = 8'b1110_0010;  // unaligned, left part
    localparam aluop_t alu_lwr_op = 8'b1110_0110;  // unaligned, right part

    // stores
    localparam aluop_t alu_sb_op  = 8'b1110_1000;
    localparam aluop_t alu_sh_op  = 8'b1110_1001;
    localparam aluop_t alu_sw_op  = 8'b1110_1011;
    localparam aluop_t alu_sc_op  = 8'b1111_1000;  // store conditional
    localparam aluop_t alu_swl_op = 8'b1110_1010;
    localparam aluop_t alu_swr_op = 8'b1110_1110;

endpackage

`default_nettype wire
